//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_rsa
FILELIST := sources.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rsa_bias_adder.sv
`timescale 1ns/1ps

module rsa_bias_adder import rsa_pkg::*; #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_load,
    input  load_req_t        i_load_req,
    input  logic             i_busy,
    input  logic             i_drain_en,
    input  data_t [ROWS-1:0] i_drain_vec,
    output logic             o_c_valid,
    output logic [IDX_W-1:0] o_c_col,
    output data_t [ROWS-1:0] o_c_data
);

    localparam int RA_W = (ROWS > 1) ? $clog2(ROWS) : 1;
    localparam int CA_W = (COLS > 1) ? $clog2(COLS) : 1;

    data_t m_mem [ROWS][COLS];

    logic [IDX_W-1:0] col;      // column now leaving the array
    logic             wr_en;

    assign wr_en = i_load && !i_busy && (i_load_req.bank == BANK_M)
                   && (int'(i_load_req.idx) < ROWS)
                   && (int'(i_load_req.pos) < COLS);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            m_mem[i_load_req.idx[RA_W-1:0]][i_load_req.pos[CA_W-1:0]] <= i_load_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            col       <= '0;
            o_c_valid <= 1'b0;
            o_c_col   <= '0;
        end else begin
            o_c_valid <= i_drain_en;
            o_c_col   <= col;
            col       <= i_drain_en ? col + IDX_W'(1) : '0;
        end
    end

    // one column of C per drain cycle
    always_ff @(posedge clk) begin
        if (i_drain_en) begin
            for (int r = 0; r < ROWS; r++) begin
                o_c_data[r] <= i_drain_vec[r] + m_mem[r][col[CA_W-1:0]];
            end
        end
    end

endmodule

//--- rsa_ctrl_fsm.sv
`timescale 1ns/1ps

module rsa_ctrl_fsm import rsa_pkg::*; #(
    parameter int ROWS  = 4,
    parameter int COLS  = 4,
    parameter int MAX_K = 8
) (
    input  logic                           clk,
    input  logic                           i_reset,
    input  logic                           i_start,
    input  logic [$clog2(MAX_K + 1)-1:0]   i_k_len,
    input  logic                           i_last_step,
    output logic                           o_busy,
    output logic [$clog2(MAX_K + 1)-1:0]   o_k_len,
    output logic [STEP_W-1:0]              o_phase_len,
    output logic                           o_cnt_load,
    output logic                           o_feed_en,
    output logic                           o_calc_done,
    output logic                           o_drain_en,
    output logic                           o_done
);

    // extra feed steps needed for the skew to reach the far corner PE
    localparam logic [STEP_W-1:0] SKEW_STEPS = STEP_W'(ROWS + COLS - 2);

    ctrl_state_e state;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state       <= ST_IDLE;
            o_busy      <= 1'b0;
            o_k_len     <= '0;
            o_phase_len <= '0;
            o_cnt_load  <= 1'b0;
            o_feed_en   <= 1'b0;
            o_calc_done <= 1'b0;
            o_drain_en  <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            // single-cycle pulses
            o_cnt_load  <= 1'b0;
            o_calc_done <= 1'b0;
            o_done      <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state       <= ST_FEED;
                        o_busy      <= 1'b1;
                        o_k_len     <= i_k_len;
                        o_phase_len <= STEP_W'(i_k_len) + SKEW_STEPS;
                        o_cnt_load  <= 1'b1;
                        o_feed_en   <= 1'b1;
                    end
                end
                ST_FEED: begin
                    if (o_calc_done) begin          // sums frozen this cycle, start draining
                        state       <= ST_DRAIN;
                        o_phase_len <= STEP_W'(COLS);
                        o_cnt_load  <= 1'b1;
                        o_drain_en  <= 1'b1;
                    end else if (i_last_step) begin
                        o_feed_en   <= 1'b0;
                        o_calc_done <= 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (i_last_step) begin
                        state      <= ST_DONE;
                        o_drain_en <= 1'b0;
                        o_done     <= 1'b1;     // lines up with the last output column
                    end
                end
                ST_DONE: begin
                    state  <= ST_IDLE;
                    o_busy <= 1'b0;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- rsa_operand_bank.sv
`timescale 1ns/1ps

module rsa_operand_bank import rsa_pkg::*; #(
    parameter int        LANES = 4,
    parameter int        MAX_K = 8,
    parameter bank_sel_e BANK  = BANK_A
) (
    input  logic                           clk,
    input  logic                           i_load,
    input  load_req_t                      i_load_req,
    input  logic                           i_busy,
    input  logic                           i_feed_en,
    input  logic [STEP_W-1:0]              i_step,
    input  logic [$clog2(MAX_K + 1)-1:0]   i_k_len,
    output data_t [LANES-1:0]              o_edge_vec
);

    localparam int LA_W = (LANES > 1) ? $clog2(LANES) : 1;   // lane address
    localparam int KA_W = (MAX_K > 1) ? $clog2(MAX_K) : 1;   // k address

    data_t mem [LANES][MAX_K];

    logic wr_en;

    assign wr_en = i_load && !i_busy && (i_load_req.bank == BANK)
                   && (int'(i_load_req.idx) < LANES)
                   && (int'(i_load_req.pos) < MAX_K);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[i_load_req.idx[LA_W-1:0]][i_load_req.pos[KA_W-1:0]] <= i_load_req.data;
        end
    end

    // diagonal skew, lane n is n steps behind lane 0
    always_comb begin
        logic [STEP_W-1:0] k;
        for (int n = 0; n < LANES; n++) begin
            k = i_step - STEP_W'(n);
            o_edge_vec[n] = '0;
            if (i_feed_en && (i_step >= STEP_W'(n))
                && (k < STEP_W'(i_k_len)) && (k < STEP_W'(MAX_K))) begin
                o_edge_vec[n] = mem[n][k[KA_W-1:0]];
            end
        end
    end

endmodule

//--- rsa_pe.sv
`timescale 1ns/1ps

module rsa_pe import rsa_pkg::*; (
    input  logic  clk,
    input  logic  i_reset,
    input  data_t i_west,
    input  data_t i_south,
    input  logic  i_start_clr,
    input  logic  i_calc_done,
    input  logic  i_drain_en,
    input  data_t i_east_drain,
    output data_t o_east,
    output data_t o_north,
    output data_t o_drain
);

    data_t acc;
    data_t prod;

    assign prod = i_west * i_south;     // low 16 bits only

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_east  <= '0;
            o_north <= '0;
            acc     <= '0;
        end else begin
            o_east  <= i_west;
            o_north <= i_south;
            // first step of a run starts a fresh sum
            if (i_start_clr) begin
                acc <= prod;
            end else begin
                acc <= acc + prod;
            end
        end
    end

    // drain chain, frozen sum then shift toward column 0
    always_ff @(posedge clk) begin
        if (i_calc_done) begin
            o_drain <= acc;
        end else if (i_drain_en) begin
            o_drain <= i_east_drain;
        end
    end

endmodule

//--- rsa_pe_array.sv
`timescale 1ns/1ps

module rsa_pe_array import rsa_pkg::*; #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic             clk,
    input  logic             i_reset,
    input  data_t [ROWS-1:0] i_west_vec,
    input  data_t [COLS-1:0] i_south_vec,
    input  logic             i_start_clr,
    input  logic             i_calc_done,
    input  logic             i_drain_en,
    output data_t [ROWS-1:0] o_drain_vec
);

    // row 0 is the south row, column 0 the west column
    data_t east  [ROWS][COLS];
    data_t north [ROWS][COLS];
    data_t drain [ROWS][COLS];

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            data_t west_in;
            data_t south_in;
            data_t drain_in;

            if (c == 0) begin : g_west_edge
                assign west_in = i_west_vec[r];
            end else begin : g_west_inner
                assign west_in = east[r][c-1];
            end

            if (r == 0) begin : g_south_edge
                assign south_in = i_south_vec[c];
            end else begin : g_south_inner
                assign south_in = north[r-1][c];
            end

            if (c == COLS - 1) begin : g_drain_end
                assign drain_in = '0;       // nothing east of the last column
            end else begin : g_drain_inner
                assign drain_in = drain[r][c+1];
            end

            rsa_pe u_pe (
                .clk          (clk),
                .i_reset      (i_reset),
                .i_west       (west_in),
                .i_south      (south_in),
                .i_start_clr  (i_start_clr),
                .i_calc_done  (i_calc_done),
                .i_drain_en   (i_drain_en),
                .i_east_drain (drain_in),
                .o_east       (east[r][c]),     // open on the last column
                .o_north      (north[r][c]),    // open on the top row
                .o_drain      (drain[r][c])
            );
        end

        assign o_drain_vec[r] = drain[r][0];
    end

endmodule

//--- rsa_pkg.sv
package rsa_pkg;

    // operand and result width, all arithmetic wraps at this size
    localparam int DATA_W = 16;

    // width of row / column / k fields in a load request, bounds ROWS, COLS, MAX_K to 16
    localparam int IDX_W = 4;

    // step counter width, covers the longest feed phase (16 + 16 + 16 - 2 steps)
    localparam int STEP_W = 6;

    typedef logic [DATA_W-1:0] data_t;

    // target of a host load
    typedef enum logic [1:0] {
        BANK_A,     // idx = row of A, pos = k
        BANK_B,     // idx = column of B, pos = k
        BANK_M      // idx = row of M, pos = column
    } bank_sel_e;

    // one host write, 26 bits
    typedef struct packed {
        bank_sel_e          bank;
        logic [IDX_W-1:0]   idx;
        logic [IDX_W-1:0]   pos;
        data_t              data;
    } load_req_t;

    // run controller states
    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for start, loads accepted
        ST_FEED,    // skewed operands stream in, then one calc_done cycle
        ST_DRAIN,   // results shift out of column 0
        ST_DONE     // last column on the outputs
    } ctrl_state_e;

endpackage

//--- rsa_step_counter.sv
`timescale 1ns/1ps

module rsa_step_counter import rsa_pkg::*; (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_load,
    input  logic [STEP_W-1:0] i_len,
    output logic [STEP_W-1:0] o_step,
    output logic              o_last_step
);

    logic [STEP_W-1:0] cnt;

    // the load cycle itself is step 0
    assign o_step = i_load ? '0 : cnt;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cnt <= '0;
        end else begin
            cnt <= o_step + STEP_W'(1);
        end
    end

    assign o_last_step = (o_step == i_len - STEP_W'(1));

endmodule

//--- rsa_top.sv
`timescale 1ns/1ps

module rsa_top import rsa_pkg::*; #(
    parameter int ROWS  = 4,
    parameter int COLS  = 4,
    parameter int MAX_K = 8
) (
    input  logic                           clk,
    input  logic                           i_reset,
    input  logic                           i_load,
    input  load_req_t                      i_load_req,
    input  logic                           i_start,
    input  logic [$clog2(MAX_K + 1)-1:0]   i_k_len,
    output logic                           o_busy,
    output logic                           o_c_valid,
    output logic [IDX_W-1:0]               o_c_col,
    output data_t [ROWS-1:0]               o_c_data,
    output logic                           o_done
);

    localparam int KW = $clog2(MAX_K + 1);

    logic              cnt_load;        // first cycle of a phase
    logic              feed_en;
    logic              calc_done;
    logic              drain_en;
    logic              last_step;
    logic [KW-1:0]     k_len;
    logic [STEP_W-1:0] phase_len;
    logic [STEP_W-1:0] step;

    data_t [ROWS-1:0]  west_vec;
    data_t [COLS-1:0]  south_vec;
    data_t [ROWS-1:0]  drain_vec;

    rsa_ctrl_fsm #(
        .ROWS  (ROWS),
        .COLS  (COLS),
        .MAX_K (MAX_K)
    ) u_ctrl (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_k_len     (i_k_len),
        .i_last_step (last_step),
        .o_busy      (o_busy),
        .o_k_len     (k_len),
        .o_phase_len (phase_len),
        .o_cnt_load  (cnt_load),
        .o_feed_en   (feed_en),
        .o_calc_done (calc_done),
        .o_drain_en  (drain_en),
        .o_done      (o_done)
    );

    rsa_step_counter u_step_cnt (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_load      (cnt_load),
        .i_len       (phase_len),
        .o_step      (step),
        .o_last_step (last_step)
    );

    // A enters the west edge, one lane per row
    rsa_operand_bank #(
        .LANES (ROWS),
        .MAX_K (MAX_K),
        .BANK  (BANK_A)
    ) u_bank_a (
        .clk        (clk),
        .i_load     (i_load),
        .i_load_req (i_load_req),
        .i_busy     (o_busy),
        .i_feed_en  (feed_en),
        .i_step     (step),
        .i_k_len    (k_len),
        .o_edge_vec (west_vec)
    );

    // B enters the south edge, one lane per column
    rsa_operand_bank #(
        .LANES (COLS),
        .MAX_K (MAX_K),
        .BANK  (BANK_B)
    ) u_bank_b (
        .clk        (clk),
        .i_load     (i_load),
        .i_load_req (i_load_req),
        .i_busy     (o_busy),
        .i_feed_en  (feed_en),
        .i_step     (step),
        .i_k_len    (k_len),
        .o_edge_vec (south_vec)
    );

    rsa_pe_array #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_array (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_west_vec  (west_vec),
        .i_south_vec (south_vec),
        .i_start_clr (cnt_load),    // phase start also restarts the sums
        .i_calc_done (calc_done),
        .i_drain_en  (drain_en),
        .o_drain_vec (drain_vec)
    );

    rsa_bias_adder #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_bias (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_load      (i_load),
        .i_load_req  (i_load_req),
        .i_busy      (o_busy),
        .i_drain_en  (drain_en),
        .i_drain_vec (drain_vec),
        .o_c_valid   (o_c_valid),
        .o_c_col     (o_c_col),
        .o_c_data    (o_c_data)
    );

endmodule

//--- sources.f
rsa_pkg.sv
rsa_step_counter.sv
rsa_operand_bank.sv
rsa_pe.sv
rsa_pe_array.sv
rsa_bias_adder.sv
rsa_ctrl_fsm.sv
rsa_top.sv
tb_rsa.sv

//--- tb_rsa.sv
`timescale 1ns/1ps

module tb_rsa import rsa_pkg::*; ();

    localparam int ROWS       = 4;
    localparam int COLS       = 4;
    localparam int MAX_K      = 8;
    localparam int KW         = $clog2(MAX_K + 1);
    localparam int CLK_PERIOD = 4;
    localparam int RUN_CYCLES = MAX_K + ROWS + 2 * COLS + 10;  // longest run plus slack

    logic             clk;
    logic             i_reset;
    logic             i_load;
    load_req_t        i_load_req;
    logic             i_start;
    logic [KW-1:0]    i_k_len;
    logic             o_busy;
    logic             o_c_valid;
    logic [IDX_W-1:0] o_c_col;
    data_t [ROWS-1:0] o_c_data;
    logic             o_done;

    // shadow copies of the accepted loads
    data_t a_sh  [ROWS][MAX_K];
    data_t b_sh  [COLS][MAX_K];
    data_t m_sh  [ROWS][COLS];
    data_t exp_c [ROWS][COLS];

    int value_errors;
    int protocol_errors;
    int runs;

    rsa_top #(.ROWS(ROWS), .COLS(COLS), .MAX_K(MAX_K)) UUT (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_load     (i_load),
        .i_load_req (i_load_req),
        .i_start    (i_start),
        .i_k_len    (i_k_len),
        .o_busy     (o_busy),
        .o_c_valid  (o_c_valid),
        .o_c_col    (o_c_col),
        .o_c_data   (o_c_data),
        .o_done     (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 40 runs worth of cycles covers reset, loads and all runs
    initial begin
        #(40 * RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the test sequence did not finish in time");
        $display("runs %0d, value errors %0d, protocol errors %0d",
                 runs, value_errors, protocol_errors);
        $display("** FAIL **");
        $finish;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            value_errors++;
            $display("Fail time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_idle();
        check_value("o_busy", 0, int'(o_busy));
        check_value("o_c_valid", 0, int'(o_c_valid));
        check_value("o_done", 0, int'(o_done));
    endtask

    // C = A*B + M with every step wrapped to 16 bits
    task automatic compute_expected(input int k);
        data_t sum;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                sum = m_sh[r][c];
                for (int j = 0; j < k; j++) begin
                    sum = sum + data_t'(a_sh[r][j] * b_sh[c][j]);
                end
                exp_c[r][c] = sum;
            end
        end
    endtask

    task automatic load_word(input bank_sel_e bank, input int idx, input int pos, input data_t d);
        check_idle();
        i_load          = 1'b1;
        i_load_req.bank = bank;
        i_load_req.idx  = IDX_W'(idx);
        i_load_req.pos  = IDX_W'(pos);
        i_load_req.data = d;
        @(posedge clk);
        #1;
        i_load = 1'b0;
    endtask

    task automatic load_random_operands();
        for (int r = 0; r < ROWS; r++) begin
            for (int j = 0; j < MAX_K; j++) begin
                a_sh[r][j] = data_t'($urandom);
                load_word(BANK_A, r, j, a_sh[r][j]);
            end
        end
        for (int c = 0; c < COLS; c++) begin
            for (int j = 0; j < MAX_K; j++) begin
                b_sh[c][j] = data_t'($urandom);
                load_word(BANK_B, c, j, b_sh[c][j]);
            end
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                m_sh[r][c] = data_t'($urandom);
                load_word(BANK_M, r, c, m_sh[r][c]);
            end
        end
    endtask

    // one start and then a look at every output cycle until o_done
    task automatic run_and_check(input int k, input bit inject);
        int cycles;
        int col_cnt;
        bit done_seen;
        cycles    = 0;
        col_cnt   = 0;
        done_seen = 1'b0;
        compute_expected(k);
        check_idle();
        i_start = 1'b1;
        i_k_len = KW'(k);
        @(posedge clk);
        #1;
        i_start = 1'b0;
        while (!done_seen && cycles < RUN_CYCLES) begin
            check_value("o_busy", 1, int'(o_busy));
            assert (o_c_valid || col_cnt == 0 || col_cnt >= COLS) else begin
                protocol_errors++;
                $display("gap in the output columns at time %0t", $time);
            end
            if (o_c_valid) begin
                assert (col_cnt < COLS) else begin
                    protocol_errors++;
                    $display("more than %0d output columns in one run at time %0t", COLS, $time);
                end
                if (col_cnt < COLS) begin
                    check_value("o_c_col", col_cnt, int'(o_c_col));
                    for (int r = 0; r < ROWS; r++) begin
                        check_value($sformatf("o_c_data[%0d]", r), int'(exp_c[r][col_cnt]),
                                    int'(o_c_data[r]));
                    end
                end
                col_cnt++;
            end
            if (o_done) begin
                done_seen = 1'b1;
                assert (o_c_valid && col_cnt == COLS) else begin
                    protocol_errors++;
                    $display("o_done at time %0t did not come with the last column", $time);
                end
            end
            if (inject) begin               // junk that the DUT has to ignore
                i_load          = 1'b1;
                i_load_req.bank = bank_sel_e'($urandom % 3);
                i_load_req.idx  = IDX_W'($urandom);
                i_load_req.pos  = IDX_W'($urandom);
                i_load_req.data = data_t'($urandom);
                i_start         = ($urandom % 4) == 0;
                i_k_len         = KW'(int'($urandom % MAX_K) + 1);
            end
            @(posedge clk);
            #1;
            i_load  = 1'b0;
            i_start = 1'b0;
            cycles++;
        end
        assert (done_seen) else begin
            protocol_errors++;
            $display("run with k_len %0d gave no o_done within %0d cycles", k, RUN_CYCLES);
        end
        check_idle();   // busy drops the cycle after done
        runs++;
    endtask

    initial begin
        int k;
        void'($urandom(94603));
        value_errors    = 0;
        protocol_errors = 0;
        runs            = 0;
        i_reset         = 1'b1;
        i_load          = 1'b0;
        i_load_req      = '0;
        i_start         = 1'b0;
        i_k_len         = '0;
        repeat (10) @(posedge clk);
        #1;
        i_reset = 1'b0;
        repeat (5) begin
            check_idle();
            @(posedge clk);
            #1;
        end

        load_random_operands();
        run_and_check(1, 1'b0);
        run_and_check(MAX_K, 1'b0);

        for (int i = 0; i < 4; i++) begin
            k = int'($urandom % MAX_K) + 1;
            load_random_operands();
            run_and_check(k, 1'b0);
            run_and_check(k, 1'b0);         // same operands without a reload
        end

        // busy traffic followed by a clean run on the untouched operands
        for (int i = 0; i < 3; i++) begin
            run_and_check(int'($urandom % MAX_K) + 1, 1'b1);
            run_and_check(int'($urandom % MAX_K) + 1, 1'b0);
        end

        $display("runs %0d, value errors %0d, protocol errors %0d",
                 runs, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
